// ==== src/commit_pkg.sv ====
// sizes and shared types of the commit slice; every depth is a power of two
// the free list holds exactly the tags that the committed map does not
`default_nettype none

package commit_pkg;

    // dispatch and retire width
    localparam int n_way = 4;
    localparam int rob_depth = 16;
    localparam int arch_regs = 32;
    localparam int phys_regs = 64;
    // tags outside the committed map
    localparam int fl_depth = phys_regs - arch_regs;

    typedef logic [$clog2(arch_regs)-1:0] arch_idx_t;
    typedef logic [$clog2(phys_regs)-1:0] phys_idx_t;
    typedef logic [$clog2(rob_depth)-1:0] rob_idx_t;

    // counts 0..n_way, for accept, grant, retire and pop
    typedef logic [$clog2(n_way+1)-1:0] lane_cnt_t;

    // occupancy, wide enough for the open count before the n_way cap
    typedef logic [$clog2(rob_depth+n_way+1)-1:0] rob_cnt_t;

    // free list position and fill level
    typedef logic [$clog2(fl_depth)-1:0] fl_idx_t;
    typedef logic [$clog2(fl_depth+1)-1:0] fl_cnt_t;

    // one reorder buffer slot, 20 bits
    typedef struct packed {
        arch_idx_t dest;
        phys_idx_t new_tag;
        // freed at retirement
        phys_idx_t old_tag;
        logic      halt;
        logic      complete;
        logic      valid;
    } rob_entry_t;

endpackage

`default_nettype wire

// ==== src/dispatch_ctrl.sv ====
// grants dispatch lanes and renames them; lane 0 is the oldest
// the producer sends no more than accept_count lanes and the rest are dropped
`timescale 1ns/1ps
`default_nettype none

module dispatch_ctrl (
    input  wire logic                                          clock,
    input  wire logic                                          reset,
    input  wire commit_pkg::lane_cnt_t                         dispatch_count,
    input  wire commit_pkg::arch_idx_t [commit_pkg::n_way-1:0] dispatch_dest,
    input  wire commit_pkg::lane_cnt_t                         rob_open,
    input  wire commit_pkg::lane_cnt_t                         fl_avail,
    input  wire commit_pkg::phys_idx_t [commit_pkg::n_way-1:0] head_tags,
    input  wire logic                                          halted,
    output commit_pkg::lane_cnt_t                              accept_count,
    output commit_pkg::lane_cnt_t                              grant_count,
    output commit_pkg::phys_idx_t [commit_pkg::n_way-1:0]      dispatch_tag,
    output commit_pkg::phys_idx_t [commit_pkg::n_way-1:0]      old_tag_out
);
    import commit_pkg::*;

    // speculative rename table
    phys_idx_t spec_map [arch_regs];

    // accept limit independent of what the producer offers
    always_comb begin
        accept_count = lane_cnt_t'(n_way);
        if (rob_open < accept_count) begin
            accept_count = rob_open;
        end
        if (fl_avail < accept_count) begin
            accept_count = fl_avail;
        end
        // nothing enters after a halt has retired
        if (halted) begin
            accept_count = '0;
        end
    end

    // lanes that actually enter this cycle
    assign grant_count = (dispatch_count < accept_count) ? dispatch_count : accept_count;

    // new tags come straight off the free list head
    assign dispatch_tag = head_tags;

    always_comb begin
        for (int i = 0; i < n_way; i++) begin
            old_tag_out[i] = spec_map[dispatch_dest[i]];
            // forward from the youngest older lane with the same dest
            for (int j = 0; j < i; j++) begin
                if (dispatch_dest[j] == dispatch_dest[i]) begin
                    old_tag_out[i] = head_tags[j];
                end
            end
        end
    end

    // lane order so a younger lane overwrites an older one
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int r = 0; r < arch_regs; r++) begin
                spec_map[r] <= phys_idx_t'(r);
            end
        end else begin
            for (int i = 0; i < n_way; i++) begin
                if (i < int'(grant_count)) begin
                    spec_map[dispatch_dest[i]] <= head_tags[i];
                end
            end
        end
    end

    // a granted lane takes a free tag and never the mapping it replaces
    for (genvar i = 0; i < n_way; i++) begin : g_fresh_chk
        assert property (@(posedge clock) disable iff (reset)
            (int'(grant_count) > i) |-> (head_tags[i] != old_tag_out[i]));
    end

endmodule

`default_nettype wire

// ==== src/reorder_buffer.sv ====
// in-order retirement of up to n_way complete entries from the head
// no squash; once a halt retires nothing else retires until reset
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer (
    input  wire logic                                          clock,
    input  wire logic                                          reset,
    input  wire commit_pkg::lane_cnt_t                         grant_count,
    input  wire commit_pkg::arch_idx_t [commit_pkg::n_way-1:0] dispatch_dest,
    input  wire logic                  [commit_pkg::n_way-1:0] dispatch_halt,
    input  wire commit_pkg::phys_idx_t [commit_pkg::n_way-1:0] dispatch_tag,
    input  wire commit_pkg::phys_idx_t [commit_pkg::n_way-1:0] dispatch_old_tag,
    input  wire logic                  [commit_pkg::n_way-1:0] complete_valid,
    input  wire commit_pkg::phys_idx_t [commit_pkg::n_way-1:0] complete_tag,
    output commit_pkg::lane_cnt_t                              rob_open,
    output commit_pkg::lane_cnt_t                              retire_count,
    output commit_pkg::arch_idx_t [commit_pkg::n_way-1:0]      retire_dest,
    output commit_pkg::phys_idx_t [commit_pkg::n_way-1:0]      retire_tag,
    output commit_pkg::phys_idx_t [commit_pkg::n_way-1:0]      retire_old_tag,
    output logic                                               halted
);
    import commit_pkg::*;

    rob_entry_t entries      [rob_depth];
    rob_entry_t next_entries [rob_depth];

    // head is the oldest entry, tail the first free slot
    rob_idx_t head;
    rob_idx_t tail;
    rob_cnt_t count;
    rob_cnt_t open_slots;

    // a halting entry retires this cycle
    logic halt_seen;

    // retirement straight from the registered entries
    always_comb begin
        rob_idx_t idx;
        logic     stop;
        stop = halted;
        halt_seen = 1'b0;
        retire_count = '0;
        retire_dest = '0;
        retire_tag = '0;
        retire_old_tag = '0;
        for (int i = 0; i < n_way; i++) begin
            idx = head + rob_idx_t'(i);
            if (!stop && entries[idx].valid && entries[idx].complete) begin
                retire_dest[i] = entries[idx].dest;
                retire_tag[i] = entries[idx].new_tag;
                retire_old_tag[i] = entries[idx].old_tag;
                retire_count = retire_count + lane_cnt_t'(1);
                // halt retires itself and younger lanes wait
                if (entries[idx].halt) begin
                    halt_seen = 1'b1;
                    stop = 1'b1;
                end
            end else begin
                // first gap ends the complete prefix
                stop = 1'b1;
            end
        end
    end

    // free slots after this cycle's retirement capped at n_way
    always_comb begin
        open_slots = rob_cnt_t'(rob_depth) - count + rob_cnt_t'(retire_count);
        if (open_slots > rob_cnt_t'(n_way)) begin
            rob_open = lane_cnt_t'(n_way);
        end else begin
            rob_open = lane_cnt_t'(open_slots);
        end
    end

    // wakeup first, then retire, then append
    // when full the tail slots are the ones retiring now
    always_comb begin
        rob_idx_t idx;
        next_entries = entries;
        // result bus wakeup against every live entry
        for (int k = 0; k < rob_depth; k++) begin
            for (int j = 0; j < n_way; j++) begin
                if (entries[k].valid && complete_valid[j] &&
                        (entries[k].new_tag == complete_tag[j])) begin
                    next_entries[k].complete = 1'b1;
                end
            end
        end
        // release retired slots
        for (int i = 0; i < n_way; i++) begin
            idx = head + rob_idx_t'(i);
            if (i < int'(retire_count)) begin
                next_entries[idx].valid = 1'b0;
            end
        end
        // granted lanes go in at the tail with lane 0 first
        for (int i = 0; i < n_way; i++) begin
            idx = tail + rob_idx_t'(i);
            if (i < int'(grant_count)) begin
                next_entries[idx] = '{
                    dest:     dispatch_dest[i],
                    new_tag:  dispatch_tag[i],
                    old_tag:  dispatch_old_tag[i],
                    halt:     dispatch_halt[i],
                    complete: 1'b0,
                    valid:    1'b1
                };
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            halted <= 1'b0;
            // clear the status bits of every slot
            for (int k = 0; k < rob_depth; k++) begin
                entries[k].valid <= 1'b0;
                entries[k].complete <= 1'b0;
            end
        end else begin
            head <= head + rob_idx_t'(retire_count);
            tail <= tail + rob_idx_t'(grant_count);
            count <= count - rob_cnt_t'(retire_count) + rob_cnt_t'(grant_count);
            // sticky until reset
            halted <= halted | halt_seen;
            entries <= next_entries;
        end
    end

    // grant from dispatch_ctrl keeps occupancy in range
    assert property (@(posedge clock) disable iff (reset)
        count <= rob_cnt_t'(rob_depth));

    // every retiring lane lies inside the occupied range
    for (genvar i = 0; i < n_way; i++) begin : g_retire_chk
        assert property (@(posedge clock) disable iff (reset)
            (int'(retire_count) > i) |-> (count > rob_cnt_t'(i)));
    end

endmodule

`default_nettype wire

// ==== src/free_list.sv ====
// circular queue of free physical tags, full of arch_regs..phys_regs-1 after reset
// pushed tags become visible at the head one cycle later
`timescale 1ns/1ps
`default_nettype none

module free_list (
    input  wire logic                                          clock,
    input  wire logic                                          reset,
    input  wire commit_pkg::lane_cnt_t                         pop_count,
    input  wire commit_pkg::lane_cnt_t                         push_count,
    input  wire commit_pkg::phys_idx_t [commit_pkg::n_way-1:0] push_tags,
    output commit_pkg::phys_idx_t [commit_pkg::n_way-1:0]      head_tags,
    output commit_pkg::lane_cnt_t                              fl_avail
);
    import commit_pkg::*;

    phys_idx_t tags [fl_depth];

    // head is the next tag to hand out, tail the next slot to fill
    fl_idx_t head;
    fl_idx_t tail;
    fl_cnt_t count;

    // next n_way tags, valid only up to fl_avail
    always_comb begin
        for (int i = 0; i < n_way; i++) begin
            head_tags[i] = tags[head + fl_idx_t'(i)];
        end
    end

    // tags present before this cycle's pops, capped at n_way
    assign fl_avail = (count > fl_cnt_t'(n_way)) ? lane_cnt_t'(n_way) : lane_cnt_t'(count);

    always_ff @(posedge clock) begin
        if (reset) begin
            // full queue, so head and tail coincide
            head <= '0;
            tail <= '0;
            count <= fl_cnt_t'(fl_depth);
            for (int k = 0; k < fl_depth; k++) begin
                tags[k] <= phys_idx_t'(arch_regs + k);
            end
        end else begin
            head <= head + fl_idx_t'(pop_count);
            tail <= tail + fl_idx_t'(push_count);
            count <= count - fl_cnt_t'(pop_count) + fl_cnt_t'(push_count);
            // retired old tags, appended in lane order
            for (int i = 0; i < n_way; i++) begin
                if (i < int'(push_count)) begin
                    tags[tail + fl_idx_t'(i)] <= push_tags[i];
                end
            end
        end
    end

    // no pop beyond what is stored
    assert property (@(posedge clock) disable iff (reset)
        fl_cnt_t'(pop_count) <= count);

    // tags are conserved: the rob never frees more than were taken out
    assert property (@(posedge clock) disable iff (reset)
        (count - fl_cnt_t'(pop_count)) <= (fl_cnt_t'(fl_depth) - fl_cnt_t'(push_count)));

endmodule

`default_nettype wire

// ==== src/arch_map.sv ====
// committed architectural map, the precise state of the core
// written only at retirement; one read port for inspection
`timescale 1ns/1ps
`default_nettype none

module arch_map (
    input  wire logic                                          clock,
    input  wire logic                                          reset,
    input  wire commit_pkg::lane_cnt_t                         retire_count,
    input  wire commit_pkg::arch_idx_t [commit_pkg::n_way-1:0] retire_dest,
    input  wire commit_pkg::phys_idx_t [commit_pkg::n_way-1:0] retire_tag,
    input  wire commit_pkg::arch_idx_t                         arch_read_idx,
    output commit_pkg::phys_idx_t                              committed_tag
);
    import commit_pkg::*;

    // arch register to physical tag
    phys_idx_t committed [arch_regs];

    always_ff @(posedge clock) begin
        if (reset) begin
            // identity map, tags 0..arch_regs-1 are live
            for (int r = 0; r < arch_regs; r++) begin
                committed[r] <= phys_idx_t'(r);
            end
        end else begin
            // lane order, a younger lane to the same register wins
            for (int i = 0; i < n_way; i++) begin
                if (i < int'(retire_count)) begin
                    committed[retire_dest[i]] <= retire_tag[i];
                end
            end
        end
    end

    // async read
    assign committed_tag = committed[arch_read_idx];

    // a retiring tag came off the free list, so it cannot be the
    // committed mapping it replaces
    for (genvar i = 0; i < n_way; i++) begin : g_fresh_chk
        assert property (@(posedge clock) disable iff (reset)
            (int'(retire_count) > i) |-> (committed[retire_dest[i]] != retire_tag[i]));
    end

endmodule

`default_nettype wire

// ==== src/commit_top.sv ====
// commit slice top: dispatch grant, reorder buffer, free list and committed map
// lane 0 is the oldest on every bus; only tags travel, no result data
`timescale 1ns/1ps
`default_nettype none

module commit_top (
    input  wire logic                                          clock,
    input  wire logic                                          reset,
    // dispatch side
    input  wire commit_pkg::lane_cnt_t                         dispatch_count,
    input  wire commit_pkg::arch_idx_t [commit_pkg::n_way-1:0] dispatch_dest,
    input  wire logic                  [commit_pkg::n_way-1:0] dispatch_halt,
    output commit_pkg::lane_cnt_t                              accept_count,
    output commit_pkg::phys_idx_t [commit_pkg::n_way-1:0]      dispatch_tag,
    // result bus
    input  wire logic                  [commit_pkg::n_way-1:0] complete_valid,
    input  wire commit_pkg::phys_idx_t [commit_pkg::n_way-1:0] complete_tag,
    // retirement
    output commit_pkg::lane_cnt_t                              retire_count,
    output commit_pkg::arch_idx_t [commit_pkg::n_way-1:0]      retire_dest,
    output commit_pkg::phys_idx_t [commit_pkg::n_way-1:0]      retire_tag,
    output logic                                               halted,
    // committed map read port
    input  wire commit_pkg::arch_idx_t                         arch_read_idx,
    output commit_pkg::phys_idx_t                              committed_tag
);
    import commit_pkg::*;

    lane_cnt_t                 grant_count;
    lane_cnt_t                 rob_open;
    lane_cnt_t                 fl_avail;
    phys_idx_t [n_way-1:0]     head_tags;
    // previous mapping of each dispatch lane
    phys_idx_t [n_way-1:0]     old_tag;
    // freed at retirement, pushed back to the free list
    phys_idx_t [n_way-1:0]     retire_old_tag;

    dispatch_ctrl i_dispatch_ctrl (
        .clock          (clock),
        .reset          (reset),
        .dispatch_count (dispatch_count),
        .dispatch_dest  (dispatch_dest),
        .rob_open       (rob_open),
        .fl_avail       (fl_avail),
        .head_tags      (head_tags),
        .halted         (halted),
        .accept_count   (accept_count),
        .grant_count    (grant_count),
        .dispatch_tag   (dispatch_tag),
        .old_tag_out    (old_tag)
    );

    reorder_buffer i_reorder_buffer (
        .clock            (clock),
        .reset            (reset),
        .grant_count      (grant_count),
        .dispatch_dest    (dispatch_dest),
        .dispatch_halt    (dispatch_halt),
        .dispatch_tag     (dispatch_tag),
        .dispatch_old_tag (old_tag),
        .complete_valid   (complete_valid),
        .complete_tag     (complete_tag),
        .rob_open         (rob_open),
        .retire_count     (retire_count),
        .retire_dest      (retire_dest),
        .retire_tag       (retire_tag),
        .retire_old_tag   (retire_old_tag),
        .halted           (halted)
    );

    free_list i_free_list (
        .clock      (clock),
        .reset      (reset),
        .pop_count  (grant_count),
        .push_count (retire_count),
        .push_tags  (retire_old_tag),
        .head_tags  (head_tags),
        .fl_avail   (fl_avail)
    );

    arch_map i_arch_map (
        .clock         (clock),
        .reset         (reset),
        .retire_count  (retire_count),
        .retire_dest   (retire_dest),
        .retire_tag    (retire_tag),
        .arch_read_idx (arch_read_idx),
        .committed_tag (committed_tag)
    );

endmodule

`default_nettype wire

// ==== tb/commit_tb.sv ====
// testbench for commit_top; runs from the project root, reads tb/commit_stim.txt
// expected values come from a model of the free list, rename table and reorder buffer
`timescale 1ns/1ps
`default_nettype none

module commit_tb;
    import commit_pkg::*;

    localparam int max_lines = 256;

    logic                  clock = 1'b0;
    logic                  reset;
    lane_cnt_t             dispatch_count;
    arch_idx_t [n_way-1:0] dispatch_dest;
    logic      [n_way-1:0] dispatch_halt;
    logic      [n_way-1:0] complete_valid;
    phys_idx_t [n_way-1:0] complete_tag;
    arch_idx_t             arch_read_idx;
    lane_cnt_t             accept_count;
    phys_idx_t [n_way-1:0] dispatch_tag;
    lane_cnt_t             retire_count;
    arch_idx_t [n_way-1:0] retire_dest;
    phys_idx_t [n_way-1:0] retire_tag;
    logic                  halted;
    phys_idx_t             committed_tag;

    // stimulus table, one row per cycle
    int st_count [max_lines];
    int st_dest  [max_lines][n_way];
    int st_halt  [max_lines];
    int st_done  [max_lines][n_way];
    int st_read  [max_lines];
    int num_lines = 0;

    // model state
    int fl_q[$];
    int spec_map [arch_regs];
    int comm_map [arch_regs];
    int rob_dest[$];
    int rob_new[$];
    int rob_old[$];
    int rob_halt[$];
    int rob_done[$];
    // tag of every dispatched instruction, by sequence number
    int seq_tags[$];
    bit model_halted = 1'b0;

    int errors = 0;
    int checks = 0;
    int watchdog_ns = 0;

    commit_top i_commit_top (
        .clock          (clock),
        .reset          (reset),
        .dispatch_count (dispatch_count),
        .dispatch_dest  (dispatch_dest),
        .dispatch_halt  (dispatch_halt),
        .accept_count   (accept_count),
        .dispatch_tag   (dispatch_tag),
        .complete_valid (complete_valid),
        .complete_tag   (complete_tag),
        .retire_count   (retire_count),
        .retire_dest    (retire_dest),
        .retire_tag     (retire_tag),
        .halted         (halted),
        .arch_read_idx  (arch_read_idx),
        .committed_tag  (committed_tag)
    );

    // 8 ns period
    always #4 clock = ~clock;

    task automatic check_value(string name, int got, int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("** Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic read_stimulus();
        int    fd;
        int    n;
        int    cnt, d0, d1, d2, d3, hm, c0, c1, c2, c3, rd;
        string line;
        fd = $fopen("tb/commit_stim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the stimulus file tb/commit_stim.txt");
            return;
        end
        while (!$feof(fd) && num_lines < max_lines) begin
            line = "";
            void'($fgets(line, fd));
            // comment and blank lines
            if (line.len() == 0 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d",
                        cnt, d0, d1, d2, d3, hm, c0, c1, c2, c3, rd);
            if (n == 11) begin
                st_count[num_lines] = cnt;
                st_dest[num_lines] = '{d0, d1, d2, d3};
                st_halt[num_lines] = hm;
                st_done[num_lines] = '{c0, c1, c2, c3};
                st_read[num_lines] = rd;
                num_lines++;
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_idle(int read_idx);
        dispatch_count = '0;
        dispatch_dest = '0;
        dispatch_halt = '0;
        complete_valid = '0;
        complete_tag = '0;
        arch_read_idx = arch_idx_t'(read_idx);
    endtask

    // completion references become tags through the dispatch log
    task automatic drive_line(int l);
        int seq_ref;
        drive_idle(st_read[l]);
        dispatch_count = lane_cnt_t'(st_count[l]);
        for (int i = 0; i < n_way; i++) begin
            dispatch_dest[i] = arch_idx_t'(st_dest[l][i]);
            dispatch_halt[i] = st_halt[l][i];
            seq_ref = st_done[l][i];
            if (seq_ref >= 0 && seq_ref < seq_tags.size()) begin
                complete_valid[i] = 1'b1;
                complete_tag[i] = phys_idx_t'(seq_tags[seq_ref]);
            end
        end
    endtask

    // compare this cycle's outputs, then advance the model past the edge
    task automatic check_and_step();
        int ret_n;
        int open_n;
        int acc_n;
        int grant_n;
        int dest;
        bit stop;
        bit halt_seen;
        int new_tag [n_way];
        int old_tag [n_way];
        ret_n = 0;
        stop = model_halted;
        halt_seen = 1'b0;
        // complete prefix from the head, a halt ends it after itself
        for (int i = 0; i < n_way; i++) begin
            if (!stop && i < rob_new.size() && rob_done[i] != 0) begin
                check_value($sformatf("retire_dest[%0d]", i), int'(retire_dest[i]), rob_dest[i]);
                check_value($sformatf("retire_tag[%0d]", i), int'(retire_tag[i]), rob_new[i]);
                ret_n++;
                if (rob_halt[i] != 0) begin
                    halt_seen = 1'b1;
                    stop = 1'b1;
                end
            end else begin
                stop = 1'b1;
            end
        end
        check_value("retire_count", int'(retire_count), ret_n);
        check_value("halted", int'(halted), int'(model_halted));
        check_value("committed_tag", int'(committed_tag), comm_map[arch_read_idx]);
        // smallest of width, rob space after retirement, free tags before pushes
        open_n = rob_depth - rob_new.size() + ret_n;
        acc_n = model_halted ? 0 : n_way;
        if (open_n < acc_n) begin
            acc_n = open_n;
        end
        if (fl_q.size() < acc_n) begin
            acc_n = fl_q.size();
        end
        check_value("accept_count", int'(accept_count), acc_n);
        grant_n = (int'(dispatch_count) < acc_n) ? int'(dispatch_count) : acc_n;
        // rename in lane order, so a younger lane sees an older lane's tag
        for (int i = 0; i < grant_n; i++) begin
            new_tag[i] = fl_q.pop_front();
            check_value($sformatf("dispatch_tag[%0d]", i), int'(dispatch_tag[i]), new_tag[i]);
            dest = int'(dispatch_dest[i]);
            old_tag[i] = spec_map[dest];
            spec_map[dest] = new_tag[i];
        end
        for (int i = 0; i < ret_n; i++) begin
            comm_map[rob_dest[0]] = rob_new[0];
            fl_q.push_back(rob_old[0]);
            void'(rob_dest.pop_front());
            void'(rob_new.pop_front());
            void'(rob_old.pop_front());
            void'(rob_halt.pop_front());
            void'(rob_done.pop_front());
        end
        // wakeup only reaches entries already in the buffer
        for (int k = 0; k < rob_new.size(); k++) begin
            for (int j = 0; j < n_way; j++) begin
                if (complete_valid[j] && rob_new[k] == int'(complete_tag[j])) begin
                    rob_done[k] = 1;
                end
            end
        end
        for (int i = 0; i < grant_n; i++) begin
            rob_dest.push_back(int'(dispatch_dest[i]));
            rob_new.push_back(new_tag[i]);
            rob_old.push_back(old_tag[i]);
            rob_halt.push_back(int'(dispatch_halt[i]));
            rob_done.push_back(0);
            seq_tags.push_back(new_tag[i]);
        end
        model_halted = model_halted | halt_seen;
    endtask

    initial begin
        reset = 1'b1;
        drive_idle(0);
        for (int r = 0; r < arch_regs; r++) begin
            spec_map[r] = r;
            comm_map[r] = r;
        end
        // free tags in ascending order
        for (int t = arch_regs; t < phys_regs; t++) begin
            fl_q.push_back(t);
        end
        read_stimulus();
        if (num_lines == 0) begin
            errors++;
            $display("no stimulus lines were read");
        end
        watchdog_ns = (8 + arch_regs + num_lines + 20) * 8;
        repeat (8) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        // sweep the committed map right after reset
        for (int r = 0; r < arch_regs; r++) begin
            drive_idle(r);
            @(posedge clock);
            check_value("committed_tag", int'(committed_tag), r);
            check_and_step();
            @(negedge clock);
        end
        for (int l = 0; l < num_lines; l++) begin
            drive_line(l);
            @(posedge clock);
            check_and_step();
            @(negedge clock);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        wait (watchdog_ns > 0);
        #(watchdog_ns);
        $display("watchdog expired after %0d ns before the stimulus ended", watchdog_ns);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/commit_stim.txt ====
# count dest0 dest1 dest2 dest3 halt_mask done0 done1 done2 done3 read_idx
# doneN is a dispatch sequence number whose tag goes on the result bus, -1 for none
4 1 2 3 1 0 -1 -1 -1 -1 1
4 4 5 6 7 0 2 0 -1 -1 1
4 8 9 10 11 0 3 1 -1 -1 2
4 12 13 14 15 0 7 5 6 4 1
4 16 17 18 19 0 -1 -1 -1 -1 3
4 20 21 22 23 0 -1 -1 -1 -1 1
3 24 25 26 0 0 -1 -1 -1 -1 20
3 24 25 26 0 0 -1 -1 -1 -1 21
3 24 25 26 0 0 10 9 -1 -1 2
3 24 25 26 0 0 8 11 -1 -1 4
3 24 25 26 0 0 12 13 14 15 8
2 27 28 0 0 0 16 17 18 19 12
4 1 1 2 2 0 20 21 22 23 16
0 0 0 0 0 0 24 25 26 27 1
0 0 0 0 0 0 28 29 30 31 2
0 0 0 0 0 0 32 -1 -1 -1 1
0 0 0 0 0 0 -1 -1 -1 -1 1
0 0 0 0 0 0 -1 -1 -1 -1 2
0 0 0 0 0 0 -1 -1 -1 -1 24
4 3 4 5 6 2 -1 -1 -1 -1 3
0 0 0 0 0 0 36 35 34 33 4
0 0 0 0 0 0 -1 -1 -1 -1 4
4 7 8 9 10 0 -1 -1 -1 -1 4
2 11 12 0 0 0 -1 -1 -1 -1 5
4 13 14 15 16 0 -1 -1 -1 -1 6
1 17 0 0 0 0 -1 -1 -1 -1 3
0 0 0 0 0 0 -1 -1 -1 -1 5

// ==== all.f ====
src/commit_pkg.sv
src/dispatch_ctrl.sv
src/reorder_buffer.sv
src/free_list.sv
src/arch_map.sv
src/commit_top.sv
tb/commit_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the commit slice testbench with Verilator, from the project root
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module commit_tb -f all.f -o commit_sim

./obj_dir/commit_sim | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
    echo "run passed"
else
    echo "run failed, see sim.log"
    exit 1
fi
